// File: common/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

    // funct5 in inst[31:27]
    localparam logic [4:0] F5_ADD    = 5'b00000;
    localparam logic [4:0] F5_SUB    = 5'b00001;
    localparam logic [4:0] F5_MUL    = 5'b00010;
    localparam logic [4:0] F5_MV_X_W = 5'b11100;
    localparam logic [4:0] F5_MV_W_X = 5'b11110;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_LOAD,
        OP_STORE,
        OP_MVXW,
        OP_MVWX
    } fpu_op_e;

    // where an E1 operand comes from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_E2,
        FWD_E3,
        FWD_E4
    } fwd_sel_e;

    // stage at whose end the result lands in the result pipeline
    localparam logic [1:0] READY_MV   = 2'd1;
    localparam logic [1:0] READY_LOAD = 2'd2;
    localparam logic [1:0] READY_ADD  = 2'd2;
    localparam logic [1:0] READY_MUL  = 2'd3;

    localparam logic [31:0] CANON_NAN = 32'h7fc00000;

endpackage

`default_nettype wire

// File: fpu/float_register.sv
`timescale 1ns/1ps
`default_nettype none

module float_register (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic        wen,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wen)
            regs[waddr] <= wdata;
    end

    // same-cycle write shows up on the read ports
    assign rdata1 = (wen && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wen && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: fpu/fpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] from_intreg,
    input  logic [31:0] from_mem,
    output logic        stall,
    output logic        mem_load,
    output logic        mem_store,
    output logic [31:0] to_mem,
    output logic        intreg_write,
    output logic [31:0] to_intreg
);
    import fpu_pkg::*;

    fpu_op_e     d_op;
    logic        d_reg_write;
    logic        d_use_rs1;
    logic        d_use_rs2;
    logic [1:0]  d_ready;
    logic        accept;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;

    logic        e1_valid, e2_valid, e3_valid, e4_valid;
    logic        e1_regw, e2_regw, e3_regw, e4_regw;
    logic        e1_wr, e2_wr, e3_wr, e4_wr;
    fpu_op_e     e1_op, e2_op, e3_op;
    logic [4:0]  e1_rd, e2_rd, e3_rd, e4_rd;
    logic [4:0]  e1_rs1, e1_rs2;
    logic [1:0]  e1_ready, e2_ready;
    logic [31:0] e1_rf1, e1_rf2;
    logic [31:0] res_e1, res_e2, res_e3, res_e4;

    fwd_sel_e    fwd_sel1;
    fwd_sel_e    fwd_sel2;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] addsub_out;
    logic [31:0] mul_out;

    function automatic logic [31:0] fwd_value(input fwd_sel_e sel, input logic [31:0] rf_val);
        case (sel)
            FWD_E2:  return res_e2;
            FWD_E3:  return res_e3;
            FWD_E4:  return res_e4;
            default: return rf_val;
        endcase
    endfunction

    fpu_decode u_decode (
        .inst        (inst),
        .op          (d_op),
        .reg_write   (d_reg_write),
        .use_rs1     (d_use_rs1),
        .use_rs2     (d_use_rs2),
        .ready_stage (d_ready)
    );

    fpu_hazard_fwd u_hazard (
        .d_rs1     (inst[19:15]),
        .d_rs2     (inst[24:20]),
        .d_use_rs1 (inst_valid & d_use_rs1),
        .d_use_rs2 (inst_valid & d_use_rs2),
        .e1_rs1    (e1_rs1),
        .e1_rs2    (e1_rs2),
        .e1_rd     (e1_rd),
        .e2_rd     (e2_rd),
        .e3_rd     (e3_rd),
        .e4_rd     (e4_rd),
        .e1_wr     (e1_wr),
        .e2_wr     (e2_wr),
        .e3_wr     (e3_wr),
        .e4_wr     (e4_wr),
        .e1_ready  (e1_ready),
        .e2_ready  (e2_ready),
        .stall     (stall),
        .fwd_sel1  (fwd_sel1),
        .fwd_sel2  (fwd_sel2)
    );

    float_register u_freg (
        .clk    (clk),
        .raddr1 (inst[19:15]),
        .raddr2 (inst[24:20]),
        .waddr  (e4_rd),
        .wdata  (res_e4),
        .wen    (e4_wr),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    fp_addsub u_addsub (
        .clk (clk),
        .a   (op1),
        .b   (op2),
        .sub (e1_op == OP_SUB),
        .sum (addsub_out)
    );

    fp_mult u_mult (
        .clk  (clk),
        .a    (op1),
        .b    (op2),
        .prod (mul_out)
    );

    assign accept = inst_valid & ~stall;
    assign e1_wr  = e1_valid & e1_regw;
    assign e2_wr  = e2_valid & e2_regw;
    assign e3_wr  = e3_valid & e3_regw;
    assign e4_wr  = e4_valid & e4_regw;

    assign op1 = fwd_value(fwd_sel1, e1_rf1);
    assign op2 = fwd_value(fwd_sel2, e1_rf2);

    assign mem_load     = e1_valid && e1_op == OP_LOAD;
    assign mem_store    = e1_valid && e1_op == OP_STORE;
    assign intreg_write = e1_valid && e1_op == OP_MVXW;
    assign to_mem       = op2;
    assign to_intreg    = op1;

    // a stall drops a bubble into E1, the later stages always move
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e1_valid <= 1'b0;
            e2_valid <= 1'b0;
            e3_valid <= 1'b0;
            e4_valid <= 1'b0;
        end else begin
            e1_valid <= accept;
            e2_valid <= e1_valid;
            e3_valid <= e2_valid;
            e4_valid <= e3_valid;
        end
    end

    always_ff @(posedge clk) begin
        e1_op    <= d_op;
        e1_regw  <= d_reg_write;
        e1_rd    <= inst[11:7];
        e1_rs1   <= inst[19:15];
        e1_rs2   <= inst[24:20];
        e1_ready <= d_ready;
        e1_rf1   <= rf_rdata1;
        e1_rf2   <= rf_rdata2;
        e2_op    <= e1_op;
        e2_regw  <= e1_regw;
        e2_rd    <= e1_rd;
        e2_ready <= e1_ready;
        e3_op    <= e2_op;
        e3_regw  <= e2_regw;
        e3_rd    <= e2_rd;
        e4_regw  <= e3_regw;
        e4_rd    <= e3_rd;

        if (accept && d_op == OP_MVWX)
            res_e1 <= from_intreg;
        res_e2 <= res_e1;
        if (e2_op == OP_ADD || e2_op == OP_SUB)
            res_e3 <= addsub_out;
        else if (e2_op == OP_LOAD)
            res_e3 <= from_mem;
        else
            res_e3 <= res_e2;
        res_e4 <= (e3_op == OP_MUL) ? mul_out : res_e3;
    end

endmodule

`default_nettype wire

// File: fpu/fpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_decode (
    input  logic [31:0]       inst,
    output fpu_pkg::fpu_op_e  op,
    output logic              reg_write,
    output logic              use_rs1,
    output logic              use_rs2,
    output logic [1:0]        ready_stage
);
    import fpu_pkg::*;

    logic [6:0] opcode;
    logic [4:0] funct5;
    logic [2:0] funct3;

    assign opcode = inst[6:0];
    assign funct5 = inst[31:27];
    assign funct3 = inst[14:12];

    always_comb begin
        op          = OP_NONE;
        reg_write   = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        ready_stage = READY_MV;
        case (opcode)
            OPC_OP_FP: begin
                case (funct5)
                    F5_ADD, F5_SUB: begin
                        op          = (funct5 == F5_SUB) ? OP_SUB : OP_ADD;
                        reg_write   = 1'b1;
                        use_rs1     = 1'b1;
                        use_rs2     = 1'b1;
                        ready_stage = READY_ADD;
                    end
                    F5_MUL: begin
                        op          = OP_MUL;
                        reg_write   = 1'b1;
                        use_rs1     = 1'b1;
                        use_rs2     = 1'b1;
                        ready_stage = READY_MUL;
                    end
                    F5_MV_X_W: begin
                        if (funct3 == 3'b000) begin
                            op      = OP_MVXW;
                            use_rs1 = 1'b1;
                        end
                    end
                    F5_MV_W_X: begin
                        // moves in only write, nothing is read from the file
                        if (funct3 == 3'b000) begin
                            op          = OP_MVWX;
                            reg_write   = 1'b1;
                            ready_stage = READY_MV;
                        end
                    end
                    default: ;
                endcase
            end
            OPC_LOAD_FP: begin
                op          = OP_LOAD;
                reg_write   = 1'b1;
                ready_stage = READY_LOAD;
            end
            OPC_STORE_FP: begin
                op      = OP_STORE;
                use_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: fpu/fpu_hazard_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_hazard_fwd (
    input  logic [4:0]         d_rs1,
    input  logic [4:0]         d_rs2,
    input  logic               d_use_rs1,
    input  logic               d_use_rs2,
    input  logic [4:0]         e1_rs1,
    input  logic [4:0]         e1_rs2,
    input  logic [4:0]         e1_rd,
    input  logic [4:0]         e2_rd,
    input  logic [4:0]         e3_rd,
    input  logic [4:0]         e4_rd,
    input  logic               e1_wr,
    input  logic               e2_wr,
    input  logic               e3_wr,
    input  logic               e4_wr,
    input  logic [1:0]         e1_ready,
    input  logic [1:0]         e2_ready,
    output logic               stall,
    output fpu_pkg::fwd_sel_e  fwd_sel1,
    output fpu_pkg::fwd_sel_e  fwd_sel2
);
    import fpu_pkg::*;

    logic rs1_blocked;
    logic rs2_blocked;

    // youngest writer wins
    function automatic fwd_sel_e pick_src(input logic [4:0] rs);
        if (e2_wr && e2_rd == rs)
            return FWD_E2;
        if (e3_wr && e3_rd == rs)
            return FWD_E3;
        if (e4_wr && e4_rd == rs)
            return FWD_E4;
        return FWD_REG;
    endfunction

    // a writer in stage k can only be forwarded once k >= its ready stage
    assign rs1_blocked = d_use_rs1 &&
                         ((e1_wr && e1_rd == d_rs1 && e1_ready > 2'd1) ||
                          (e2_wr && e2_rd == d_rs1 && e2_ready > 2'd2));
    assign rs2_blocked = d_use_rs2 &&
                         ((e1_wr && e1_rd == d_rs2 && e1_ready > 2'd1) ||
                          (e2_wr && e2_rd == d_rs2 && e2_ready > 2'd2));

    assign stall    = rs1_blocked || rs2_blocked;
    assign fwd_sel1 = pick_src(e1_rs1);
    assign fwd_sel2 = pick_src(e1_rs2);

endmodule

`default_nettype wire

// File: logic/fp_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module fp_addsub (
    input  logic        clk,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        sub,
    output logic [31:0] sum
);
    import fpu_pkg::*;

    logic              sign_b;
    logic [23:0]       man_a, man_b;
    logic [30:0]       mag_a, mag_b;
    logic              a_big;
    logic [7:0]        exp_big, diff;
    logic [26:0]       big_ext, small_ext, shifted, lost_mask, aligned;
    logic              sticky;

    logic              r_sign, r_sub, r_nan;
    logic [7:0]        r_exp;
    logic [26:0]       r_big, r_small;

    logic [27:0]       raw;
    logic [26:0]       norm;
    logic [4:0]        lz;
    logic [22:0]       frac;
    logic signed [9:0] exp_n;

    function automatic logic [4:0] lead_zeros(input logic [26:0] v);
        logic [4:0] n;
        n = 5'd27;
        for (int i = 0; i < 27; i++) begin
            if (v[i])
                n = 5'(26 - i);
        end
        return n;
    endfunction

    // stage one: unpack, flush subnormals, order by magnitude, align
    always_comb begin
        sign_b  = b[31] ^ sub;
        man_a   = (a[30:23] == 8'd0) ? 24'd0 : {1'b1, a[22:0]};
        man_b   = (b[30:23] == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
        mag_a   = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
        mag_b   = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
        a_big   = mag_a >= mag_b;
        exp_big = a_big ? a[30:23] : b[30:23];
        diff    = a_big ? a[30:23] - b[30:23] : b[30:23] - a[30:23];
        big_ext   = {(a_big ? man_a : man_b), 3'b000};
        small_ext = {(a_big ? man_b : man_a), 3'b000};
        lost_mask = '0;
        if (diff > 8'd26) begin
            shifted = '0;
            sticky  = |small_ext;
        end else begin
            shifted   = small_ext >> diff;
            lost_mask = (27'd1 << diff) - 27'd1;
            sticky    = |(small_ext & lost_mask);
        end
        aligned = {shifted[26:1], shifted[0] | sticky};
    end

    always_ff @(posedge clk) begin
        r_sign  <= a_big ? a[31] : sign_b;
        r_sub   <= a[31] ^ sign_b;
        r_nan   <= (a[30:23] == 8'hff) || (b[30:23] == 8'hff);
        r_exp   <= exp_big;
        r_big   <= big_ext;
        r_small <= aligned;
    end

    // stage two: add, normalize, truncate, pack
    always_comb begin
        raw  = r_sub ? {1'b0, r_big} - {1'b0, r_small} : {1'b0, r_big} + {1'b0, r_small};
        lz   = lead_zeros(raw[26:0]);
        norm = raw[26:0] << lz;
        if (raw[27]) begin
            frac  = raw[26:4];
            exp_n = 10'(r_exp) + 10'sd1;
        end else begin
            frac  = norm[25:3];
            exp_n = 10'(r_exp) - 10'(lz);
        end
        if (r_nan)
            sum = CANON_NAN;
        else if (raw == 28'd0)
            sum = 32'd0;
        else if (exp_n <= 0)
            sum = {r_sign, 31'd0};
        else if (exp_n >= 255)
            sum = {r_sign, 8'hff, 23'd0};
        else
            sum = {r_sign, exp_n[7:0], frac};
    end

endmodule

`default_nettype wire

// File: logic/fp_mult.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mult (
    input  logic        clk,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] prod
);
    import fpu_pkg::*;

    logic              s1_sign, s1_zero, s1_nan;
    logic signed [9:0] s1_exp;
    logic [47:0]       s1_prod;

    logic              s2_sign, s2_zero, s2_nan;
    logic signed [9:0] s2_exp;
    logic [22:0]       s2_frac;

    // stage one: mantissa product, biased exponent sum, sign
    always_ff @(posedge clk) begin
        s1_sign <= a[31] ^ b[31];
        s1_zero <= (a[30:23] == 8'd0) || (b[30:23] == 8'd0);
        s1_nan  <= (a[30:23] == 8'hff) || (b[30:23] == 8'hff);
        s1_exp  <= 10'(a[30:23]) + 10'(b[30:23]) - 10'sd127;
        s1_prod <= 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
    end

    // stage two: product is in [1,4), so at most one bit of normalization
    always_ff @(posedge clk) begin
        s2_sign <= s1_sign;
        s2_zero <= s1_zero;
        s2_nan  <= s1_nan;
        if (s1_prod[47]) begin
            s2_frac <= s1_prod[46:24];
            s2_exp  <= s1_exp + 10'sd1;
        end else begin
            s2_frac <= s1_prod[45:23];
            s2_exp  <= s1_exp;
        end
    end

    // stage three: specials, range checks, pack
    always_comb begin
        if (s2_nan)
            prod = CANON_NAN;
        else if (s2_zero || s2_exp <= 0)
            prod = {s2_sign, 31'd0};
        else if (s2_exp >= 255)
            prod = {s2_sign, 8'hff, 23'd0};
        else
            prod = {s2_sign, s2_exp[7:0], s2_frac};
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the FPU testbench, exit status follows the result
verilator --binary --timing --top-module fpu_tb -f sources.f -o fpu_sim \
    && ./obj_dir/fpu_sim | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
common/fpu_pkg.sv
fpu/fpu_decode.sv
fpu/fpu_hazard_fwd.sv
fpu/float_register.sv
logic/fp_addsub.sv
logic/fp_mult.sv
fpu/fpu_core.sv
verif/clk_gen.sv
verif/fpu_tb.sv

// File: verif/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // power-on reset held for 3 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

    localparam int N_LINES = 48;
    localparam logic [31:0] RESET_MARK = 32'hffffffff;

    logic        clk;
    logic        por_n;
    logic        soft_rst_n;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] from_intreg;
    logic [31:0] from_mem;
    logic        stall;
    logic        mem_load;
    logic        mem_store;
    logic [31:0] to_mem;
    logic        intreg_write;
    logic [31:0] to_intreg;

    logic [31:0] trace_mem [0:4*N_LINES-1];
    logic [31:0] exp_q [$];
    logic [31:0] load_q [$];
    logic        saw_stall;

    assign rst_n = por_n & soft_rst_n;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (por_n)
    );

    fpu_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .from_intreg  (from_intreg),
        .from_mem     (from_mem),
        .stall        (stall),
        .mem_load     (mem_load),
        .mem_store    (mem_store),
        .to_mem       (to_mem),
        .intreg_write (intreg_write),
        .to_intreg    (to_intreg)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    function automatic logic is_store(input logic [31:0] w);
        return w[6:0] == 7'b0100111;
    endfunction

    function automatic logic is_load(input logic [31:0] w);
        return w[6:0] == 7'b0000111;
    endfunction

    function automatic logic is_mul(input logic [31:0] w);
        return w[6:0] == 7'b1010011 && w[31:27] == 5'b00010;
    endfunction

    function automatic logic is_move_out(input logic [31:0] w);
        return w[6:0] == 7'b1010011 && w[31:27] == 5'b11100 && w[14:12] == 3'b000;
    endfunction

    // outputs are compared mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (mem_store || intreg_write) begin
            if (exp_q.size() == 0)
                stop_with_failure("an output strobe appeared with no instruction expecting it");
            else if (mem_store)
                check(to_mem, exp_q.pop_front(), "to_mem");
            else
                check(to_intreg, exp_q.pop_front(), "to_intreg");
        end
    end

    // memory answers a load in the cycle after mem_load
    always @(negedge clk) begin
        if (mem_load) begin
            if (load_q.size() == 0)
                stop_with_failure("mem_load was raised with no load pending");
            @(posedge clk);
            #1 from_mem = load_q.pop_front();
        end
    end

    initial begin
        #(N_LINES * 6 * 8 + 200);
        stop_with_failure("timeout: the trace did not complete in time");
    end

    initial begin
        logic [31:0] word;
        logic        accepted;
        logic        after_mul;
        inst_valid  = 1'b0;
        inst        = 32'd0;
        from_intreg = 32'd0;
        from_mem    = 32'd0;
        soft_rst_n  = 1'b1;
        saw_stall   = 1'b0;
        after_mul   = 1'b0;
        $readmemh("verif/fpu_trace.txt", trace_mem);

        wait (por_n === 1'b1);
        @(negedge clk);
        check({31'd0, stall}, 32'd0, "stall after reset");
        check({31'd0, mem_load}, 32'd0, "mem_load after reset");
        check({31'd0, mem_store}, 32'd0, "mem_store after reset");
        check({31'd0, intreg_write}, 32'd0, "intreg_write after reset");
        @(posedge clk);
        #1;

        for (int i = 0; i < N_LINES; i++) begin
            word = trace_mem[4*i];
            if (word == RESET_MARK) begin
                while (exp_q.size() != 0)
                    @(negedge clk);
                @(posedge clk);
                #1;
                // the instruction offered during reset must never come out
                soft_rst_n  = 1'b0;
                inst        = trace_mem[4*i+1];
                inst_valid  = 1'b1;
                repeat (3) @(posedge clk);
                #1;
                soft_rst_n = 1'b1;
                inst_valid = 1'b0;
                after_mul  = 1'b0;
                exp_q.delete();
                load_q.delete();
            end else begin
                inst        = word;
                from_intreg = trace_mem[4*i+1];
                inst_valid  = 1'b1;
                accepted    = 1'b0;
                while (!accepted) begin
                    @(negedge clk);
                    if (stall) begin
                        if (after_mul)
                            saw_stall = 1'b1;
                    end else begin
                        accepted = 1'b1;
                    end
                    @(posedge clk);
                    #1;
                end
                inst_valid = 1'b0;
                after_mul  = is_mul(word);
                if (is_store(word) || is_move_out(word))
                    exp_q.push_back(trace_mem[4*i+3]);
                if (is_load(word))
                    load_q.push_back(trace_mem[4*i+2]);
            end
        end

        while (exp_q.size() != 0 || load_q.size() != 0)
            @(negedge clk);
        repeat (8) @(posedge clk);
        check({31'd0, saw_stall}, 32'd1, "stall seen right after an fmul");

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fpu_trace.txt
// columns: instruction  from_intreg  from_mem  expected to_mem or to_intreg
// FFFFFFFF asserts reset while the word in column two is offered
F00000D3 3f800000 00000000 00000000
F0000153 40000000 00000000 00000000
F00001D3 3f800001 00000000 00000000
F0000253 33800000 00000000 00000000
F00002D3 7f000000 00000000 00000000
F0000353 00400000 00000000 00000000
F00003D3 7f800000 00000000 00000000
F0000453 c0400000 00000000 00000000
F00004D3 7f800001 00000000 00000000
F0000A53 80800000 00000000 00000000
E0048253 00000000 00000000 7f800001
E0008253 00000000 00000000 3f800000
00208553 00000000 00000000 00000000
00A02027 00000000 00000000 40400000
081185D3 00000000 00000000 00000000
00B02027 00000000 00000000 34000000
00418653 00000000 00000000 00000000
00C02027 00000000 00000000 3f800001
081086D3 00000000 00000000 00000000
00D02027 00000000 00000000 00000000
00130753 00000000 00000000 00000000
00E02027 00000000 00000000 3f800000
005287D3 00000000 00000000 00000000
00F02027 00000000 00000000 7f800000
00138853 00000000 00000000 00000000
01002027 00000000 00000000 7fc00000
001408D3 00000000 00000000 00000000
01102027 00000000 00000000 c0000000
10240953 00000000 00000000 00000000
01202027 00000000 00000000 c0c00000
114209D3 00000000 00000000 00000000
01302027 00000000 00000000 80000000
10228AD3 00000000 00000000 00000000
01502027 00000000 00000000 7f800000
00002B07 00000000 12345678 00000000
01602027 00000000 00000000 12345678
10208BD3 00000000 00000000 00000000
017B8C53 00000000 00000000 00000000
01802027 00000000 00000000 40800000
10208CD3 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
019C8D53 00000000 00000000 00000000
00000000 00000000 00000000 00000000
01A02027 00000000 00000000 40800000
FFFFFFFF 00102027 00000000 00000000
F00000D3 40490fdb 00000000 00000000
00102027 00000000 00000000 40490fdb
